// ==== common/histCtrlPkg.sv ====
package histCtrlPkg;

    // which pass of the two-pass histogram is running
    typedef enum logic [0:0] {
        PHASE_COARSE,
        PHASE_FINE
    } histPhase;

    // builder sequencing: count samples, flag the end, wait for the peak
    typedef enum logic [1:0] {
        B_ACQ,
        B_WAIT_PEAK,
        B_DONE
    } builderState;

    // detector sequencing
    typedef enum logic [1:0] {
        D_IDLE,
        D_SCAN,
        D_DRAIN,
        D_REPORT
    } detectState;

    // bin memory command
    typedef enum logic [1:0] {
        MEM_NOP,
        MEM_INC,
        MEM_READCLR
    } memOp;

endpackage

// ==== common/histDataPkg.sv ====
package histDataPkg;

    // sample code width, coarse field sits in the upper bits
    localparam int DEF_SAMPLE_WIDTH = 6;

    // coarse field width, the fine field is whatever is left
    localparam int DEF_COARSE_BITS = 3;

    // per-bin counter width
    // must hold DEF_ACQ_LENGTH without wrapping
    localparam int DEF_COUNT_WIDTH = 5;

    // counted samples per pass
    localparam int DEF_ACQ_LENGTH = 16;

endpackage

// ==== histogram/histBuilder.sv ====
`timescale 1ns/1ps

module histBuilder import histCtrlPkg::*; #(
    parameter int sampleWidth = 6,
    parameter int coarseBits  = 3,
    parameter int acqLength   = 16
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wrEn,
    input  logic [sampleWidth-1:0]     roughData,
    input  logic                       peakValid,
    input  logic [binBitsOf(sampleWidth, coarseBits)-1:0] peakIndex,
    input  histPhase                   peakPhase,
    output logic                       sampleReady,
    output memOp                       incOp,
    output logic [binBitsOf(sampleWidth, coarseBits)-1:0] incIndex,
    output logic                       acqDone,
    output histPhase                   acqPhase
);

    // memory index is wide enough for either field
    function automatic int binBitsOf(input int width, input int coarse);
        binBitsOf = (coarse > width - coarse) ? coarse : width - coarse;
    endfunction

    localparam int fineBits = sampleWidth - coarseBits;
    localparam int binBits  = binBitsOf(sampleWidth, coarseBits);
    localparam int cntWidth = $clog2(acqLength + 1);

    builderState state;
    histPhase    phase;

    // coarse peak from the first pass, filter for the second
    logic [coarseBits-1:0] coarsePeak;
    logic [cntWidth-1:0]   acqCount;

    logic [coarseBits-1:0] coarseField;
    logic [fineBits-1:0]   fineField;
    logic                  accepted;
    logic                  counted;
    logic                  lastSample;

    assign coarseField = roughData[sampleWidth-1 -: coarseBits];
    assign fineField   = roughData[fineBits-1:0];

    // ready only while acquiring, scan gap is back-pressured
    assign sampleReady = (state == B_ACQ);
    assign accepted    = wrEn && sampleReady;

    // fine pass keeps only samples under the coarse peak
    assign counted    = accepted && ((phase == PHASE_COARSE) || (coarseField == coarsePeak));
    assign lastSample = counted && (acqCount == cntWidth'(acqLength - 1));

    assign incOp    = counted ? MEM_INC : MEM_NOP;
    assign incIndex = (phase == PHASE_COARSE) ? binBits'(coarseField) : binBits'(fineField);

    // one-cycle pulse right after the last counted sample
    assign acqDone  = (state == B_DONE);
    assign acqPhase = phase;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= B_ACQ;
            phase      <= PHASE_COARSE;
            coarsePeak <= '0;
            acqCount   <= '0;
        end else begin
            case (state)
                B_ACQ: begin
                    if (lastSample) begin
                        acqCount <= '0;
                        state    <= B_DONE;
                    end else if (counted) begin
                        acqCount <= acqCount + 1'b1;
                    end
                end
                B_DONE: begin
                    state <= B_WAIT_PEAK;
                end
                B_WAIT_PEAK: begin
                    if (peakValid) begin
                        // coarse result arms the fine filter
                        if (peakPhase == PHASE_COARSE) begin
                            coarsePeak <= peakIndex[coarseBits-1:0];
                            phase      <= PHASE_FINE;
                        end else begin
                            phase <= PHASE_COARSE;
                        end
                        state <= B_ACQ;
                    end
                end
                default: begin
                    state <= B_ACQ;
                end
            endcase
        end
    end

endmodule

// ==== histogram/binMemory.sv ====
`timescale 1ns/1ps

module binMemory import histCtrlPkg::*; #(
    parameter int binBits    = 3,
    parameter int countWidth = 5
) (
    input  logic                  clk,
    input  logic                  reset,
    input  memOp                  incOp,
    input  logic [binBits-1:0]    incIndex,
    input  memOp                  scanOp,
    input  logic [binBits-1:0]    scanIndex,
    output logic [countWidth-1:0] binCount
);

    localparam int numBins = 2 ** binBits;

    logic [countWidth-1:0] mem [numBins];

    // second increment stage, write pending for the next edge
    logic                  wrValid;
    logic [binBits-1:0]    wrIndex;
    logic [countWidth-1:0] wrCount;

    logic                  incActive;
    logic                  clrActive;
    logic [binBits-1:0]    rdIndex;
    logic [countWidth-1:0] rdCount;

    // increment wins, scan only when no sample is counted
    assign incActive = (incOp == MEM_INC);
    assign clrActive = !incActive && (scanOp == MEM_READCLR);
    assign rdIndex   = incActive ? incIndex : scanIndex;

    // forward the in-flight write so back-to-back hits see the new count
    assign rdCount = (wrValid && (wrIndex == rdIndex)) ? wrCount : mem[rdIndex];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numBins; i++) begin
                mem[i] <= '0;
            end
            wrValid  <= 1'b0;
            wrIndex  <= '0;
            wrCount  <= '0;
            binCount <= '0;
        end else begin
            // stage 1, read and add
            wrValid <= incActive;
            wrIndex <= incIndex;
            wrCount <= rdCount + 1'b1;

            // stage 2, commit
            if (wrValid) begin
                mem[wrIndex] <= wrCount;
            end

            // read-and-clear, a clear after a pending write to the same bin wins
            if (clrActive) begin
                binCount       <= rdCount;
                mem[scanIndex] <= '0;
            end
        end
    end

endmodule

// ==== logic/peakDetector.sv ====
`timescale 1ns/1ps

module peakDetector import histCtrlPkg::*; #(
    parameter int binBits    = 3,
    parameter int countWidth = 5
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  acqDone,
    input  histPhase              acqPhase,
    input  logic [countWidth-1:0] binCount,
    output memOp                  scanOp,
    output logic [binBits-1:0]    scanIndex,
    output logic                  peakValid,
    output logic [binBits-1:0]    peakIndex,
    output histPhase              peakPhase,
    output logic [binBits-1:0]    peakCoarse,
    output logic [binBits-1:0]    peakFine,
    output logic                  peakDone
);

    detectState state;
    histPhase   phaseReg;

    logic [binBits-1:0]    scanIdx;

    // index of the count arriving this cycle
    logic                  cmpValid;
    logic [binBits-1:0]    cmpIndex;

    logic [countWidth-1:0] bestCount;
    logic [binBits-1:0]    bestIndex;

    logic                  takeNew;
    logic [binBits-1:0]    finalIndex;

    // strictly greater keeps the lowest index on ties
    assign takeNew    = cmpValid && (binCount > bestCount);
    assign finalIndex = takeNew ? cmpIndex : bestIndex;

    assign scanOp    = (state == D_SCAN) ? MEM_READCLR : MEM_NOP;
    assign scanIndex = scanIdx;

    assign peakValid = (state == D_REPORT);
    assign peakIndex = bestIndex;
    assign peakPhase = phaseReg;
    assign peakDone  = peakValid && (phaseReg == PHASE_FINE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= D_IDLE;
            phaseReg   <= PHASE_COARSE;
            scanIdx    <= '0;
            cmpValid   <= 1'b0;
            cmpIndex   <= '0;
            bestCount  <= '0;
            bestIndex  <= '0;
            peakCoarse <= '0;
            peakFine   <= '0;
        end else begin
            // memory answers one cycle after the command
            cmpValid <= (state == D_SCAN);
            cmpIndex <= scanIdx;

            if (takeNew) begin
                bestCount <= binCount;
                bestIndex <= cmpIndex;
            end

            case (state)
                D_IDLE: begin
                    if (acqDone) begin
                        phaseReg  <= acqPhase;
                        scanIdx   <= '0;
                        bestCount <= '0;
                        bestIndex <= '0;
                        state     <= D_SCAN;
                    end
                end
                D_SCAN: begin
                    scanIdx <= scanIdx + 1'b1;
                    if (scanIdx == '1) begin
                        state <= D_DRAIN;
                    end
                end
                D_DRAIN: begin
                    // last count compared here, result is final
                    if (phaseReg == PHASE_COARSE) begin
                        peakCoarse <= finalIndex;
                    end else begin
                        peakFine <= finalIndex;
                    end
                    state <= D_REPORT;
                end
                D_REPORT: begin
                    state <= D_IDLE;
                end
                default: begin
                    state <= D_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/hisSubsystem.sv ====
`timescale 1ns/1ps

module hisSubsystem import histCtrlPkg::*, histDataPkg::*; #(
    parameter int sampleWidth = DEF_SAMPLE_WIDTH,
    parameter int coarseBits  = DEF_COARSE_BITS,
    parameter int countWidth  = DEF_COUNT_WIDTH,
    parameter int acqLength   = DEF_ACQ_LENGTH,
    // one shared memory, sized for the wider of the two fields
    localparam int binBits = (coarseBits > sampleWidth - coarseBits) ?
                             coarseBits : sampleWidth - coarseBits
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wrEn,
    input  logic [sampleWidth-1:0] roughData,
    output logic                   sampleReady,
    output logic [binBits-1:0]     peakCoarse,
    output logic [binBits-1:0]     peakFine,
    output logic                   peakDone
);

    // builder to memory
    memOp                  incOp;
    logic [binBits-1:0]    incIndex;

    // builder to detector
    logic                  acqDone;
    histPhase              acqPhase;

    // detector and memory
    memOp                  scanOp;
    logic [binBits-1:0]    scanIndex;
    logic [countWidth-1:0] binCount;

    // detector back to builder
    logic                  peakValid;
    logic [binBits-1:0]    peakIndex;
    histPhase              peakPhase;

    histBuilder #(
        .sampleWidth(sampleWidth),
        .coarseBits (coarseBits),
        .acqLength  (acqLength)
    ) builder_i (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .roughData  (roughData),
        .peakValid  (peakValid),
        .peakIndex  (peakIndex),
        .peakPhase  (peakPhase),
        .sampleReady(sampleReady),
        .incOp      (incOp),
        .incIndex   (incIndex),
        .acqDone    (acqDone),
        .acqPhase   (acqPhase)
    );

    binMemory #(
        .binBits   (binBits),
        .countWidth(countWidth)
    ) memory_i (
        .clk      (clk),
        .reset    (reset),
        .incOp    (incOp),
        .incIndex (incIndex),
        .scanOp   (scanOp),
        .scanIndex(scanIndex),
        .binCount (binCount)
    );

    peakDetector #(
        .binBits   (binBits),
        .countWidth(countWidth)
    ) detector_i (
        .clk       (clk),
        .reset     (reset),
        .acqDone   (acqDone),
        .acqPhase  (acqPhase),
        .binCount  (binCount),
        .scanOp    (scanOp),
        .scanIndex (scanIndex),
        .peakValid (peakValid),
        .peakIndex (peakIndex),
        .peakPhase (peakPhase),
        .peakCoarse(peakCoarse),
        .peakFine  (peakFine),
        .peakDone  (peakDone)
    );

endmodule

// ==== dv/hisSubsystem_props.sv ====
`timescale 1ns/1ps

module hisSubsystemProps #(
    parameter int binBits = 3
) (
    input logic               clk,
    input logic               reset,
    input logic               sampleReady,
    input logic               acqDone,
    input logic               peakValid,
    input logic               peakDone,
    input logic [binBits-1:0] peakCoarse,
    input logic [binBits-1:0] peakFine
);

    // end of acquisition while back-pressured, input reopens once the peak is back
    acqDoneNotReady: assert property (@(posedge clk) disable iff (reset)
        acqDone |-> !sampleReady ##11 sampleReady)
        else $error("sampleReady not low at acqDone or not high again 11 cycles later");

    // scan of all bins plus drain and report
    peakAfterScan: assert property (@(posedge clk) disable iff (reset)
        acqDone |-> ##10 peakValid)
        else $error("peakValid missing 10 cycles after acqDone");

    // no stray result without a matching acquisition
    peakHasCause: assert property (@(posedge clk) disable iff (reset)
        peakValid |-> $past(acqDone, 10))
        else $error("peakValid without acqDone 10 cycles earlier");

    // first cycle out of reset
    quietAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> (sampleReady && !acqDone && !peakValid && !peakDone &&
                          (peakCoarse == '0) && (peakFine == '0)))
        else $error("outputs not at reset values after reset");

endmodule

// ==== dv/hisChecker.sv ====
`timescale 1ns/1ps

module hisChecker import histDataPkg::*; #(
    parameter int sampleWidth = DEF_SAMPLE_WIDTH,
    parameter int coarseBits  = DEF_COARSE_BITS,
    parameter int binBits     = 3,
    parameter int acqLength   = DEF_ACQ_LENGTH,
    parameter int nameBytes   = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wrEn,
    input  logic [sampleWidth-1:0] roughData,
    input  logic                   sampleReady,
    input  logic [binBits-1:0]     peakCoarse,
    input  logic [binBits-1:0]     peakFine,
    input  logic                   peakDone,
    input  logic [8*nameBytes-1:0] testName,
    output int                     passCount,
    output int                     failCount
);

    localparam int fineBits = sampleWidth - coarseBits;
    localparam int numBins  = 2 ** binBits;

    logic [coarseBits-1:0] cField;
    logic [fineBits-1:0]   fField;

    // model histograms, unused upper bins stay zero
    int coarseHist [numBins];
    int fineHist   [numBins];
    int counted;
    // 0 coarse pass, 1 fine pass, 2 waiting for the result
    int modelPhase;
    int expCoarse;
    int expFine;
    logic resetSeen;

    assign cField = roughData[sampleWidth-1:fineBits];
    assign fField = roughData[fineBits-1:0];

    // most frequent bin, first one found on a tie
    function automatic int lowestPeak(input int hist [numBins]);
        int best;
        int idx;
        best = 0;
        idx  = 0;
        for (int i = 0; i < numBins; i++) begin
            if (hist[i] > best) begin
                best = hist[i];
                idx  = i;
            end
        end
        lowestPeak = idx;
    endfunction

    task automatic clearModel();
        for (int i = 0; i < numBins; i++) begin
            coarseHist[i] = 0;
            fineHist[i]   = 0;
        end
        counted    = 0;
        modelPhase = 0;
    endtask

    initial begin
        passCount = 0;
        failCount = 0;
        resetSeen = 1'b0;
        clearModel();
    end

    always @(posedge clk) begin
        if (reset) begin
            clearModel();
            resetSeen = 1'b1;
        end else begin
            // first cycle out of reset
            if (resetSeen) begin
                resetSeen = 1'b0;
                if (sampleReady && !peakDone && (peakCoarse == '0) && (peakFine == '0)) begin
                    $display("PASS reset");
                    passCount++;
                end else begin
                    $write("FAIL reset: expected ready=1 done=0 coarse=0 fine=0, ");
                    $display("actual ready=%0b done=%0b coarse=%0d fine=%0d",
                             sampleReady, peakDone, peakCoarse, peakFine);
                    failCount++;
                end
            end

            if (wrEn && sampleReady) begin
                case (modelPhase)
                    0: begin
                        coarseHist[cField]++;
                        counted++;
                        if (counted == acqLength) begin
                            expCoarse  = lowestPeak(coarseHist);
                            counted    = 0;
                            modelPhase = 1;
                        end
                    end
                    1: begin
                        // off-peak samples are consumed, not counted
                        if (int'(cField) == expCoarse) begin
                            fineHist[fField]++;
                            counted++;
                            if (counted == acqLength) begin
                                expFine    = lowestPeak(fineHist);
                                modelPhase = 2;
                            end
                        end
                    end
                    default: begin
                        $display("error in %s: sample accepted while the peaks were being computed",
                                 testName);
                        failCount++;
                    end
                endcase
            end

            if (peakDone) begin
                if (modelPhase != 2) begin
                    $display("error in %s: result arrived before both passes were counted",
                             testName);
                    failCount++;
                end else if ((int'(peakCoarse) == expCoarse) && (int'(peakFine) == expFine)) begin
                    $display("PASS %s coarse=%0d fine=%0d", testName, peakCoarse, peakFine);
                    passCount++;
                end else begin
                    $display("FAIL %s: expected coarse=%0d fine=%0d, actual coarse=%0d fine=%0d",
                             testName, expCoarse, expFine, peakCoarse, peakFine);
                    failCount++;
                end
                // next test starts from empty histograms
                clearModel();
            end
        end
    end

endmodule

// ==== dv/hisSubsystemTb.sv ====
`timescale 1ns/1ps

module hisSubsystemTb import histDataPkg::*; ();

    localparam int sampleWidth = DEF_SAMPLE_WIDTH;
    localparam int coarseBits  = DEF_COARSE_BITS;
    localparam int countWidth  = DEF_COUNT_WIDTH;
    localparam int acqLength   = DEF_ACQ_LENGTH;
    localparam int fineBits    = sampleWidth - coarseBits;
    localparam int binBits     = (coarseBits > fineBits) ? coarseBits : fineBits;
    localparam int numCoarse   = 2 ** coarseBits;
    localparam int numFine     = 2 ** fineBits;
    localparam int numRows     = 6;
    localparam int nameBytes   = 16;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   wrEn;
    logic [sampleWidth-1:0] roughData;
    logic                   sampleReady;
    logic [binBits-1:0]     peakCoarse;
    logic [binBits-1:0]     peakFine;
    logic                   peakDone;

    logic [8*nameBytes-1:0] testName;
    int                     passCount;
    int                     failCount;
    int                     budgetCycles = 0;

    // stimulus table, tie -1 means a single favored bin
    string rowName  [numRows];
    int    rowCoarse[numRows];
    int    rowFine  [numRows];
    int    rowNoise [numRows];
    logic  rowGap   [numRows];
    int    rowTie   [numRows];

    // samples of the current pass, head is on the bus
    logic [sampleWidth-1:0] passQueue[$];

    always #10 clk = ~clk;

    hisSubsystem #(
        .sampleWidth(sampleWidth),
        .coarseBits (coarseBits),
        .countWidth (countWidth),
        .acqLength  (acqLength)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .roughData  (roughData),
        .sampleReady(sampleReady),
        .peakCoarse (peakCoarse),
        .peakFine   (peakFine),
        .peakDone   (peakDone)
    );

    hisChecker #(
        .sampleWidth(sampleWidth),
        .coarseBits (coarseBits),
        .binBits    (binBits),
        .acqLength  (acqLength),
        .nameBytes  (nameBytes)
    ) checker_i (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .roughData  (roughData),
        .sampleReady(sampleReady),
        .peakCoarse (peakCoarse),
        .peakFine   (peakFine),
        .peakDone   (peakDone),
        .testName   (testName),
        .passCount  (passCount),
        .failCount  (failCount)
    );

    bind hisSubsystem hisSubsystemProps #(.binBits(binBits)) props_i (
        .clk        (clk),
        .reset      (reset),
        .sampleReady(sampleReady),
        .acqDone    (acqDone),
        .peakValid  (peakValid),
        .peakDone   (peakDone),
        .peakCoarse (peakCoarse),
        .peakFine   (peakFine)
    );

    task automatic setRow(input int r, input string name, input int c, input int f,
                          input int noise, input logic gap, input int tie);
        rowName[r]   = name;
        rowCoarse[r] = c;
        rowFine[r]   = f;
        rowNoise[r]  = noise;
        rowGap[r]    = gap;
        rowTie[r]    = tie;
    endtask

    // noise stays at 6 or below so the favored coarse bin always wins
    task automatic loadTable();
        setRow(0, "plain",       3, 6, 0, 1'b0, -1);
        setRow(1, "noisy",       6, 1, 4, 1'b0, -1);
        setRow(2, "fineNoise",   1, 4, 6, 1'b1, -1);
        setRow(3, "tie",         2, 3, 0, 1'b0, 5);
        setRow(4, "repeat",      7, 7, 0, 1'b0, -1);
        setRow(5, "afterRepeat", 0, 0, 2, 1'b1, -1);
    endtask

    function automatic logic [8*nameBytes-1:0] packName(input string s);
        packName = '0;
        for (int i = 0; i < s.len() && i < nameBytes; i++) begin
            packName = {packName[8*nameBytes-9:0], s[i]};
        end
    endfunction

    function automatic logic [sampleWidth-1:0] makeSample(input int c, input int f);
        logic [coarseBits-1:0] cf;
        logic [fineBits-1:0]   ff;
        cf = coarseBits'(c);
        ff = fineBits'(f);
        makeSample = {cf, ff};
    endfunction

    function automatic int randBelow(input int n);
        randBelow = int'($urandom_range(n - 1, 0));
    endfunction

    task automatic buildCoarse(input int r);
        int peakCount;
        logic [sampleWidth-1:0] s;
        passQueue.delete();
        peakCount = acqLength - rowNoise[r];
        for (int i = 0; i < peakCount; i++) begin
            // tie rows split the peak evenly over two coarse bins
            if (rowTie[r] >= 0 && (i % 2 == 1)) begin
                s = makeSample(rowTie[r], rowFine[r]);
            end else begin
                s = makeSample(rowCoarse[r], rowFine[r]);
            end
            passQueue.push_back(s);
        end
        for (int i = 0; i < rowNoise[r]; i++) begin
            s = makeSample(randBelow(numCoarse), randBelow(numFine));
            passQueue.insert(randBelow(passQueue.size() + 1), s);
        end
    endtask

    task automatic buildFine(input int r);
        int peakCount;
        int offBin;
        logic [sampleWidth-1:0] s;
        passQueue.delete();
        peakCount = acqLength - rowNoise[r];
        for (int i = 0; i < peakCount; i++) begin
            if (rowTie[r] >= 0 && (i % 2 == 1)) begin
                s = makeSample(rowCoarse[r], rowTie[r]);
            end else begin
                s = makeSample(rowCoarse[r], rowFine[r]);
            end
            passQueue.push_back(s);
        end
        // matching coarse field, random fine field
        for (int i = 0; i < rowNoise[r]; i++) begin
            s = makeSample(rowCoarse[r], randBelow(numFine));
            passQueue.insert(randBelow(passQueue.size() + 1), s);
        end
        // off-peak extras never go last, the pass must end on a counted sample
        for (int i = 0; i < rowNoise[r]; i++) begin
            offBin = (rowCoarse[r] + 1 + randBelow(numCoarse - 1)) % numCoarse;
            s = makeSample(offBin, randBelow(numFine));
            passQueue.insert(randBelow(passQueue.size()), s);
        end
    endtask

    // valid/ready drive, head stays on the bus until accepted
    task automatic drivePass(input logic gapRow);
        int   acceptCount;
        logic accepted;
        acceptCount = 0;
        while (passQueue.size() > 0) begin
            @(posedge clk);
            accepted = wrEn && sampleReady;
            if (accepted) begin
                void'(passQueue.pop_front());
                acceptCount++;
            end
            if (passQueue.size() == 0) begin
                wrEn <= 1'b0;
            end else if (gapRow && accepted && (acceptCount % 3 == 0)) begin
                // one idle cycle after every third accepted sample
                wrEn <= 1'b0;
            end else begin
                wrEn      <= 1'b1;
                roughData <= passQueue[0];
            end
        end
    endtask

    initial begin
        reset     <= 1'b1;
        wrEn      <= 1'b0;
        roughData <= '0;
        testName  <= packName("reset");
        void'($urandom(14));
        loadTable();

        // nominal row length doubled for idle cycles
        for (int r = 0; r < numRows; r++) begin
            budgetCycles += 2 * (2 * (acqLength + rowNoise[r] + 12) + 20);
        end
        budgetCycles += 3;

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        for (int r = 0; r < numRows; r++) begin
            testName <= packName(rowName[r]);
            buildCoarse(r);
            drivePass(rowGap[r]);
            // first fine sample is offered during the scan gap
            buildFine(r);
            drivePass(rowGap[r]);
            // stray samples offered while the peaks are computed must be refused
            do begin
                @(posedge clk);
                wrEn      <= !peakDone;
                roughData <= makeSample(randBelow(numCoarse), randBelow(numFine));
            end while (!peakDone);
        end

        repeat (2) @(posedge clk);
        $display("tests run %0d, passed %0d, failed %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0 && passCount == numRows + 1) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (budgetCycles > 0);
        repeat (budgetCycles) @(posedge clk);
        $display("timeout, run did not finish within %0d cycles", budgetCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
common/histCtrlPkg.sv
common/histDataPkg.sv
histogram/histBuilder.sv
histogram/binMemory.sv
logic/peakDetector.sv
logic/hisSubsystem.sv
dv/hisSubsystem_props.sv
dv/hisChecker.sv
dv/hisSubsystemTb.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' src.f)

obj_dir/VhisSubsystemTb: src.f $(SOURCES)
	verilator --binary --timing --assert --top-module hisSubsystemTb -f src.f -o VhisSubsystemTb

run: obj_dir/VhisSubsystemTb
	@out="$$(./obj_dir/VhisSubsystemTb)"; echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean
